// ==== design/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and address width
`define CPU_XLEN 32

// General registers, register 0 reads as zero
`define CPU_NREGS 16
`define CPU_RSEL_W 4

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== design/cpu_pkg.sv ====
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_SUB  = 4'h2,
		OP_AND  = 4'h3,
		OP_OR   = 4'h4,
		OP_XOR  = 4'h5,
		OP_SHL  = 4'h6,
		OP_ADDI = 4'h7,
		OP_LDW  = 4'h8,
		OP_STW  = 4'h9,
		OP_BEQ  = 4'ha,
		OP_HALT = 4'hb	// 4'hc to 4'hf unused
	} opcode_e;

	// Opcode byte holds an opcode_e in its low nibble, upper nibble zero
	typedef struct packed {
		logic [7:0] opcode;
		logic [`CPU_RSEL_W-1:0] rd;
		logic [`CPU_RSEL_W-1:0] ra;
		logic [`CPU_RSEL_W-1:0] rb;
		logic [11:0] unused;
	} instr_r_t;

	typedef struct packed {
		logic [7:0] opcode;
		logic [`CPU_RSEL_W-1:0] rd;
		logic [`CPU_RSEL_W-1:0] ra;
		logic [15:0] imm;	// Signed
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	typedef struct packed {
		logic valid;
		instr_u instr;
		logic [`CPU_XLEN-1:0] pc_plus_4;
	} fd_t;

	typedef struct packed {
		logic valid;
		opcode_e opcode;
		logic [`CPU_RSEL_W-1:0] rd;
		logic [`CPU_RSEL_W-1:0] ra_sel;
		logic [`CPU_RSEL_W-1:0] rb_sel;
		logic [`CPU_XLEN-1:0] imm32;
		logic [`CPU_XLEN-1:0] pc_plus_4;
		logic write_rd;
		logic use_imm;
		logic load;
		logic store;
		logic branch;
		logic halt;
	} de_t;

	typedef struct packed {
		logic valid;
		logic load;
		logic store;
		logic write_rd;
		logic [`CPU_RSEL_W-1:0] rd;
		logic [`CPU_XLEN-1:0] alu_out;	// Result or memory address
		logic [`CPU_XLEN-1:0] store_val;
	} em_t;

	typedef struct packed {
		logic write_rd;
		logic [`CPU_RSEL_W-1:0] rd;
		logic [`CPU_XLEN-1:0] wr_val;
	} mw_t;

endpackage

`default_nettype wire

// ==== design/cpu_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_fetch (
	input wire clk,
	input wire i_rst_n,
	input wire i_i_ack,
	input wire [`CPU_XLEN-1:0] i_i_data,
	input wire i_hold,
	input wire i_redirect,
	input wire [`CPU_XLEN-1:0] i_target,
	input wire i_halt,
	output logic o_i_req,
	output logic [`CPU_XLEN-1:0] o_i_addr,
	output cpu_pkg::fd_t o_fd,
	output logic o_halted
);

	typedef enum logic [1:0] {F_IDLE, F_REQ, F_DONE} fstate_e;

	fstate_e state;
	logic [`CPU_XLEN-1:0] pc;	// Next address to request
	logic kill;	// Word in flight is from a flushed path
	logic fd_valid;
	cpu_pkg::instr_u fd_instr;
	logic [`CPU_XLEN-1:0] fd_pc4;
	logic fd_free;
	logic take;
	logic capture;

	assign fd_free = !fd_valid || !i_hold;
	// Ack is held until req drops, so a full slot just delays the drop
	assign take = (state == F_REQ) && i_i_ack && (kill || i_redirect || fd_free);
	assign capture = take && !kill && !i_redirect;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= F_IDLE;
			pc <= `CPU_RESET_PC;
			kill <= 1'b0;
			o_i_req <= 1'b0;
			o_halted <= 1'b0;
			fd_valid <= 1'b0;
		end else begin
			o_halted <= o_halted || (i_halt && state == F_IDLE);
			if (i_redirect)
				pc <= i_target;
			case (state)
			F_IDLE: begin
				if (!i_halt && !i_redirect) begin
					o_i_req <= 1'b1;
					pc <= pc + `CPU_XLEN'd4;
					state <= F_REQ;
				end
			end
			F_REQ: begin
				if (take) begin
					o_i_req <= 1'b0;
					state <= F_DONE;
				end
			end
			F_DONE: begin
				if (!i_i_ack)
					state <= F_IDLE;	// Four-phase cycle closed
			end
			default: state <= F_IDLE;
			endcase

			if (take)
				kill <= 1'b0;
			else if (i_redirect && state == F_REQ)
				kill <= 1'b1;

			if (i_redirect)
				fd_valid <= 1'b0;
			else if (capture)
				fd_valid <= 1'b1;
			else if (!i_hold)
				fd_valid <= 1'b0;	// Taken by decode, bubble follows
		end
	end

	always_ff @(posedge clk) begin
		if (state == F_IDLE)
			o_i_addr <= pc;	// Req is low here
		if (capture) begin
			fd_instr <= i_i_data;
			fd_pc4 <= o_i_addr + `CPU_XLEN'd4;
		end
	end

	assign o_fd = '{valid: fd_valid, instr: fd_instr, pc_plus_4: fd_pc4};

endmodule

`default_nettype wire

// ==== design/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_decode (
	input wire clk,
	input wire i_rst_n,
	input wire cpu_pkg::fd_t i_fd,
	input wire i_hold,
	input wire i_flush,
	output logic [`CPU_RSEL_W-1:0] o_ra_sel,
	output logic [`CPU_RSEL_W-1:0] o_rb_sel,
	output cpu_pkg::de_t o_de
);

	cpu_pkg::instr_u ins;
	cpu_pkg::de_t de_d;
	logic [7:0] op_raw;
	logic [`CPU_XLEN-1:0] imm_sx;

	always_comb begin
		ins = i_fd.instr;
		op_raw = ins.r.opcode;
		imm_sx = {{(`CPU_XLEN-16){ins.i.imm[15]}}, ins.i.imm};
		de_d = '0;
		de_d.valid = i_fd.valid;
		de_d.pc_plus_4 = i_fd.pc_plus_4;
		if (op_raw[7:4] == 4'h0)
			de_d.opcode = cpu_pkg::opcode_e'(op_raw[3:0]);
		else
			de_d.opcode = cpu_pkg::OP_NOP;

		case (de_d.opcode)
		cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
		cpu_pkg::OP_XOR, cpu_pkg::OP_SHL: begin
			de_d.rd = ins.r.rd;
			de_d.ra_sel = ins.r.ra;
			de_d.rb_sel = ins.r.rb;
			de_d.write_rd = 1'b1;
		end
		cpu_pkg::OP_ADDI, cpu_pkg::OP_LDW: begin
			de_d.rd = ins.i.rd;
			de_d.ra_sel = ins.i.ra;
			de_d.imm32 = imm_sx;
			de_d.use_imm = 1'b1;
			de_d.write_rd = 1'b1;
			de_d.load = (de_d.opcode == cpu_pkg::OP_LDW);
		end
		cpu_pkg::OP_STW: begin
			de_d.ra_sel = ins.i.ra;
			de_d.rb_sel = ins.i.rd;	// Store data
			de_d.imm32 = imm_sx;
			de_d.use_imm = 1'b1;
			de_d.store = 1'b1;
		end
		cpu_pkg::OP_BEQ: begin
			de_d.ra_sel = ins.i.ra;
			de_d.rb_sel = ins.i.rd;	// Compared against ra
			de_d.imm32 = imm_sx;
			de_d.branch = 1'b1;
		end
		cpu_pkg::OP_HALT: de_d.halt = 1'b1;
		default: de_d.opcode = cpu_pkg::OP_NOP;	// Undefined codes too
		endcase
	end

	// Held item keeps its selects so the registered reads stay in line
	assign o_ra_sel = i_hold ? o_de.ra_sel : de_d.ra_sel;
	assign o_rb_sel = i_hold ? o_de.rb_sel : de_d.rb_sel;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_de <= '0;
		else if (i_flush)
			o_de.valid <= 1'b0;
		else if (!i_hold)
			o_de <= de_d;
	end

endmodule

`default_nettype wire

// ==== design/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_regfile (
	input wire clk,
	input wire i_rst_n,
	input wire [`CPU_RSEL_W-1:0] i_ra_sel,
	input wire [`CPU_RSEL_W-1:0] i_rb_sel,
	input wire cpu_pkg::mw_t i_mw,
	output logic [`CPU_XLEN-1:0] o_ra,
	output logic [`CPU_XLEN-1:0] o_rb
);

	logic [`CPU_XLEN-1:0] regs [1:`CPU_NREGS-1];	// No storage for r0

	function automatic logic [`CPU_XLEN-1:0] rd_port(input logic [`CPU_RSEL_W-1:0] sel);
		if (sel == '0)
			return '0;
		if (i_mw.write_rd && i_mw.rd == sel)
			return i_mw.wr_val;	// Same-cycle write
		return regs[sel];
	endfunction

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 1; i < `CPU_NREGS; i++)
				regs[i] <= '0;
			o_ra <= '0;
			o_rb <= '0;
		end else begin
			if (i_mw.write_rd && i_mw.rd != '0)
				regs[i_mw.rd] <= i_mw.wr_val;
			o_ra <= rd_port(i_ra_sel);
			o_rb <= rd_port(i_rb_sel);
		end
	end

endmodule

`default_nettype wire

// ==== design/cpu_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_exec (
	input wire clk,
	input wire i_rst_n,
	input wire cpu_pkg::de_t i_de,
	input wire [`CPU_XLEN-1:0] i_ra,
	input wire [`CPU_XLEN-1:0] i_rb,
	input wire i_hold,
	output cpu_pkg::em_t o_em,
	output logic o_redirect,
	output logic [`CPU_XLEN-1:0] o_target,
	output logic o_halt
);

	logic live;
	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] alu;
	logic taken;

	// Item behind a taken branch or after HALT is dropped here
	assign live = i_de.valid && !o_redirect && !o_halt;
	assign op_b = i_de.use_imm ? i_de.imm32 : i_rb;
	assign taken = live && i_de.branch && (i_ra == i_rb);

	always_comb begin
		case (i_de.opcode)
		cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI,
		cpu_pkg::OP_LDW, cpu_pkg::OP_STW: alu = i_ra + op_b;	// Address for LDW/STW
		cpu_pkg::OP_SUB: alu = i_ra - op_b;
		cpu_pkg::OP_AND: alu = i_ra & op_b;
		cpu_pkg::OP_OR:  alu = i_ra | op_b;
		cpu_pkg::OP_XOR: alu = i_ra ^ op_b;
		cpu_pkg::OP_SHL: alu = i_ra << op_b[4:0];
		default: alu = '0;
		endcase
	end

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_em <= '0;
			o_redirect <= 1'b0;
			o_halt <= 1'b0;
		end else begin
			o_redirect <= 1'b0;
			if (i_hold) begin
				o_em.valid <= 1'b0;
				o_em.load <= 1'b0;
				o_em.store <= 1'b0;
				o_em.write_rd <= 1'b0;
			end else begin
				o_em.valid <= live;
				o_em.load <= live && i_de.load;
				o_em.store <= live && i_de.store;
				o_em.write_rd <= live && i_de.write_rd;
				o_em.rd <= i_de.rd;
				o_em.alu_out <= alu;
				o_em.store_val <= i_rb;
				o_redirect <= taken;
				o_halt <= o_halt || (live && i_de.halt);	// Sticky
			end
		end
	end

	// Word offset from the next instruction
	always_ff @(posedge clk)
		o_target <= i_de.pc_plus_4 + (i_de.imm32 << 2);

endmodule

`default_nettype wire

// ==== design/cpu_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_memory (
	input wire clk,
	input wire i_rst_n,
	input wire cpu_pkg::em_t i_em,
	input wire i_d_ack,
	input wire [`CPU_XLEN-1:0] i_d_rdata,
	output logic o_d_req,
	output logic o_d_we,
	output logic [`CPU_XLEN-1:0] o_d_addr,
	output logic [`CPU_XLEN-1:0] o_d_wdata,
	output logic o_busy,
	output cpu_pkg::mw_t o_mw
);

	typedef enum logic [1:0] {M_IDLE, M_REQ, M_DONE} mstate_e;

	mstate_e state;
	logic accept;
	logic ld_q;	// Open access is a load that writes rd
	logic [`CPU_RSEL_W-1:0] rd_q;
	logic [`CPU_XLEN-1:0] ld_data;

	assign accept = (state == M_IDLE) && i_em.valid && (i_em.load || i_em.store);
	// Busy already in the accept cycle so execute does not overwrite em
	assign o_busy = (state != M_IDLE) || accept;

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= M_IDLE;
			o_d_req <= 1'b0;
			o_d_we <= 1'b0;
			ld_q <= 1'b0;
			o_mw <= '0;
		end else begin
			o_mw.write_rd <= 1'b0;
			case (state)
			M_IDLE: begin
				if (accept) begin
					o_d_req <= 1'b1;
					o_d_we <= i_em.store;
					ld_q <= i_em.load && i_em.write_rd;
					state <= M_REQ;
				end else begin
					o_mw.write_rd <= i_em.valid && i_em.write_rd;
					o_mw.rd <= i_em.rd;
					o_mw.wr_val <= i_em.alu_out;
				end
			end
			M_REQ: begin
				if (i_d_ack) begin
					o_d_req <= 1'b0;
					o_d_we <= 1'b0;
					state <= M_DONE;
				end
			end
			M_DONE: begin
				if (!i_d_ack) begin
					o_mw.write_rd <= ld_q;
					o_mw.rd <= rd_q;
					o_mw.wr_val <= ld_data;
					state <= M_IDLE;
				end
			end
			default: state <= M_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_d_addr <= i_em.alu_out;
			o_d_wdata <= i_em.store_val;
			rd_q <= i_em.rd;
		end
		if (state == M_REQ && i_d_ack)
			ld_data <= i_d_rdata;
	end

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_core (
	input wire clk,
	input wire i_rst_n,
	input wire i_i_ack,
	input wire [`CPU_XLEN-1:0] i_i_data,
	input wire i_d_ack,
	input wire [`CPU_XLEN-1:0] i_d_rdata,
	output logic o_i_req,
	output logic [`CPU_XLEN-1:0] o_i_addr,
	output logic o_d_req,
	output logic o_d_we,
	output logic [`CPU_XLEN-1:0] o_d_addr,
	output logic [`CPU_XLEN-1:0] o_d_wdata,
	output logic o_halted
);

	cpu_pkg::fd_t fd;
	cpu_pkg::de_t de;
	cpu_pkg::em_t em;
	cpu_pkg::mw_t mw;
	logic [`CPU_RSEL_W-1:0] ra_sel;
	logic [`CPU_RSEL_W-1:0] rb_sel;
	logic [`CPU_XLEN-1:0] rf_ra;
	logic [`CPU_XLEN-1:0] rf_rb;
	logic [`CPU_XLEN-1:0] ex_ra;
	logic [`CPU_XLEN-1:0] ex_rb;
	logic [`CPU_XLEN-1:0] target;
	logic redirect;
	logic halt;
	logic mem_busy;
	logic load_use;
	logic hold;

	// Youngest producer wins, a load in em has no data yet
	function automatic logic [`CPU_XLEN-1:0] fwd(input logic [`CPU_RSEL_W-1:0] sel,
			input logic [`CPU_XLEN-1:0] rf_val, input cpu_pkg::em_t e,
			input cpu_pkg::mw_t w);
		if (sel == '0)
			return rf_val;
		if (e.valid && e.write_rd && !e.load && e.rd == sel)
			return e.alu_out;
		if (w.write_rd && w.rd == sel)
			return w.wr_val;
		return rf_val;
	endfunction

	assign ex_ra = fwd(de.ra_sel, rf_ra, em, mw);
	assign ex_rb = fwd(de.rb_sel, rf_rb, em, mw);

	assign load_use = de.valid && em.valid && em.load && em.write_rd && em.rd != '0 &&
		(em.rd == de.ra_sel || em.rd == de.rb_sel);
	assign hold = mem_busy || load_use;

	cpu_fetch fetch_i (.clk(clk), .i_rst_n(i_rst_n), .i_i_ack(i_i_ack), .i_i_data(i_i_data),
		.i_hold(hold), .i_redirect(redirect), .i_target(target), .i_halt(halt),
		.o_i_req(o_i_req), .o_i_addr(o_i_addr), .o_fd(fd), .o_halted(o_halted));

	cpu_decode decode_i (.clk(clk), .i_rst_n(i_rst_n), .i_fd(fd), .i_hold(hold),
		.i_flush(redirect), .o_ra_sel(ra_sel), .o_rb_sel(rb_sel), .o_de(de));

	cpu_regfile regfile_i (.clk(clk), .i_rst_n(i_rst_n), .i_ra_sel(ra_sel),
		.i_rb_sel(rb_sel), .i_mw(mw), .o_ra(rf_ra), .o_rb(rf_rb));

	cpu_exec exec_i (.clk(clk), .i_rst_n(i_rst_n), .i_de(de), .i_ra(ex_ra), .i_rb(ex_rb),
		.i_hold(hold), .o_em(em), .o_redirect(redirect), .o_target(target),
		.o_halt(halt));

	cpu_memory memory_i (.clk(clk), .i_rst_n(i_rst_n), .i_em(em), .i_d_ack(i_d_ack),
		.i_d_rdata(i_d_rdata), .o_d_req(o_d_req), .o_d_we(o_d_we), .o_d_addr(o_d_addr),
		.o_d_wdata(o_d_wdata), .o_busy(mem_busy), .o_mw(mw));

endmodule

`default_nettype wire

// ==== bench/cpu_tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_clock (
	output logic o_clk
);

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;	// 10 ns period
	end

endmodule

`default_nettype wire

// ==== bench/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_properties (
	input wire clk,
	input wire i_rst_n,
	input wire i_i_req,
	input wire i_i_ack,
	input wire [`CPU_XLEN-1:0] i_i_addr,
	input wire i_d_req,
	input wire i_d_ack,
	input wire i_d_we,
	input wire [`CPU_XLEN-1:0] i_d_addr,
	input wire [`CPU_XLEN-1:0] i_d_wdata,
	input wire i_halted
);

	int fail_count = 0;	// Read by the testbench at the end of the run

	i_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_i_req && !i_i_ack |=> i_i_req)
		else begin $error("instruction req dropped before ack"); fail_count++; end

	d_req_held: assert property (@(posedge clk) disable iff (!i_rst_n)
		i_d_req && !i_d_ack |=> i_d_req)
		else begin $error("data req dropped before ack"); fail_count++; end

	i_addr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		$past(i_i_req) && i_i_req |-> $stable(i_i_addr))
		else begin $error("instruction address moved during req"); fail_count++; end

	d_addr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		$past(i_d_req) && i_d_req |-> $stable({i_d_addr, i_d_wdata, i_d_we}))
		else begin $error("data address or write data moved during req"); fail_count++; end

	// New cycle only once the previous ack is gone
	i_req_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(i_i_req) |-> !$past(i_i_ack))
		else begin $error("instruction req rose while ack high"); fail_count++; end

	d_req_rise: assert property (@(posedge clk) disable iff (!i_rst_n)
		$rose(i_d_req) |-> !$past(i_d_ack))
		else begin $error("data req rose while ack high"); fail_count++; end

	halted_in_reset: assert property (@(posedge clk) !i_rst_n |-> !i_halted)
		else begin $error("halted set during reset"); fail_count++; end

endmodule

bind cpu_core cpu_properties props_i (.clk(clk), .i_rst_n(i_rst_n), .i_i_req(o_i_req),
	.i_i_ack(i_i_ack), .i_i_addr(o_i_addr), .i_d_req(o_d_req), .i_d_ack(i_d_ack),
	.i_d_we(o_d_we), .i_d_addr(o_d_addr), .i_d_wdata(o_d_wdata), .i_halted(o_halted));

`default_nettype wire

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module cpu_tb;

	localparam int MAX_PROG_LEN = 20;
	localparam int N_TESTS = 6;
	localparam int TIMEOUT_CYCLES = 40 * MAX_PROG_LEN * N_TESTS;

	wire clk;
	logic rst_n = 1'b0;
	logic i_ack = 1'b0;
	logic [`CPU_XLEN-1:0] i_data = '0;
	logic d_ack = 1'b0;
	logic [`CPU_XLEN-1:0] d_rdata = '0;
	logic i_req;
	logic [`CPU_XLEN-1:0] i_addr;
	logic d_req;
	logic d_we;
	logic [`CPU_XLEN-1:0] d_addr;
	logic [`CPU_XLEN-1:0] d_wdata;
	logic halted;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:63];
	logic [31:0] dmem_init [0:63];	// Image copied into dmem during reset
	int prog_len = 0;
	int cycle_count = 0;
	logic [31:0] i_rng = 32'h1af7;
	logic [31:0] d_rng = 32'h1af7;
	int i_wait = 0;
	int d_wait = 0;

	cpu_tb_clock clock_i (.o_clk(clk));

	cpu_core dut_i (.clk(clk), .i_rst_n(rst_n), .i_i_ack(i_ack), .i_i_data(i_data),
		.i_d_ack(d_ack), .i_d_rdata(d_rdata), .o_i_req(i_req), .o_i_addr(i_addr),
		.o_d_req(d_req), .o_d_we(d_we), .o_d_addr(d_addr), .o_d_wdata(d_wdata),
		.o_halted(halted));

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] fill_word(input int k);
		return 32'h5a00_0000 + k * 32'h0001_0101;
	endfunction

	function automatic logic [31:0] asm_r(input cpu_pkg::opcode_e op, input logic [3:0] rd,
			input logic [3:0] ra, input logic [3:0] rb);
		cpu_pkg::instr_u w;
		w.r = '{opcode: {4'h0, op}, rd: rd, ra: ra, rb: rb, unused: 12'h000};
		return w;
	endfunction

	function automatic logic [31:0] asm_i(input cpu_pkg::opcode_e op, input logic [3:0] rd,
			input logic [3:0] ra, input logic [15:0] imm);
		cpu_pkg::instr_u w;
		w.i = '{opcode: {4'h0, op}, rd: rd, ra: ra, imm: imm};
		return w;
	endfunction

	// Instruction memory, ack after 1 to 3 cycles
	always @(negedge clk) begin
		if (!rst_n) begin
			i_ack <= 1'b0;
			i_wait <= 0;
		end else if (i_ack) begin
			if (!i_req)
				i_ack <= 1'b0;
		end else if (i_req) begin
			if (i_wait == 0) begin
				i_rng = lcg_next(i_rng);
				i_wait <= int'((i_rng >> 16) % 3) + 1;
			end else if (i_wait == 1) begin
				i_data <= imem[i_addr[7:2]];
				i_ack <= 1'b1;
				i_wait <= 0;
			end else
				i_wait <= i_wait - 1;
		end
	end

	always @(negedge clk) begin
		if (!rst_n) begin
			d_ack <= 1'b0;
			d_wait <= 0;
			for (int k = 0; k < 64; k++)
				dmem[k] <= dmem_init[k];
		end else if (d_ack) begin
			if (!d_req)
				d_ack <= 1'b0;
		end else if (d_req) begin
			if (d_wait == 0) begin
				d_rng = lcg_next(d_rng);
				d_wait <= int'((d_rng >> 16) % 3) + 1;
			end else if (d_wait == 1) begin
				if (d_we)
					dmem[d_addr[7:2]] <= d_wdata;
				else
					d_rdata <= dmem[d_addr[7:2]];
				d_ack <= 1'b1;
				d_wait <= 0;
			end else
				d_wait <= d_wait - 1;
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout, core never halted");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_mem(input int idx, input logic [31:0] exp);
		check_eq($sformatf("dmem[%0d]", idx), dmem[idx], exp);
	endtask

	task automatic new_program();
		for (int k = 0; k < 64; k++) begin
			imem[k] = asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'(k));	// Runaway fetch halts
			dmem_init[k] = fill_word(k);
		end
		prog_len = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		imem[prog_len] = word;
		prog_len++;
	endtask

	task automatic reset_core();
		@(negedge clk);
		rst_n <= 1'b0;
		repeat (8) @(negedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic run_program();
		reset_core();
		@(negedge clk);
		while (!halted)
			@(negedge clk);
	endtask

	task automatic test_alu();
		logic [31:0] a;
		logic [31:0] b;
		a = 32'h0000_1234;
		b = 32'hffff_ffa9;	// 16'hffa9 sign-extended
		new_program();
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'h1234));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd2, 4'd0, 16'hffa9));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd3, 4'd0, 16'd5));
		emit(asm_r(cpu_pkg::OP_ADD, 4'd4, 4'd1, 4'd2));
		emit(asm_i(cpu_pkg::OP_STW, 4'd4, 4'd0, 16'd0));
		emit(asm_r(cpu_pkg::OP_SUB, 4'd5, 4'd1, 4'd2));
		emit(asm_i(cpu_pkg::OP_STW, 4'd5, 4'd0, 16'd4));
		emit(asm_r(cpu_pkg::OP_AND, 4'd6, 4'd1, 4'd2));
		emit(asm_i(cpu_pkg::OP_STW, 4'd6, 4'd0, 16'd8));
		emit(asm_r(cpu_pkg::OP_OR, 4'd7, 4'd1, 4'd2));
		emit(asm_i(cpu_pkg::OP_STW, 4'd7, 4'd0, 16'd12));
		emit(asm_r(cpu_pkg::OP_XOR, 4'd8, 4'd1, 4'd2));
		emit(asm_i(cpu_pkg::OP_STW, 4'd8, 4'd0, 16'd16));
		emit(asm_r(cpu_pkg::OP_SHL, 4'd9, 4'd1, 4'd3));
		emit(asm_i(cpu_pkg::OP_STW, 4'd9, 4'd0, 16'd20));
		emit(asm_i(cpu_pkg::OP_STW, 4'd1, 4'd0, 16'd24));
		emit(asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'd0));
		run_program();
		check_mem(0, a + b);
		check_mem(1, a - b);
		check_mem(2, a & b);
		check_mem(3, a | b);
		check_mem(4, a ^ b);
		check_mem(5, a << 5);
		check_mem(6, a);
	endtask

	task automatic test_forwarding();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		logic [31:0] r5;
		logic [31:0] r6;
		new_program();
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'd3));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd2, 4'd1, 16'd4));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd3, 4'd1, 16'd10));
		emit(asm_r(cpu_pkg::OP_ADD, 4'd4, 4'd2, 4'd3));
		emit(asm_r(cpu_pkg::OP_SUB, 4'd5, 4'd4, 4'd1));
		emit(asm_r(cpu_pkg::OP_ADD, 4'd4, 4'd4, 4'd4));
		emit(asm_r(cpu_pkg::OP_ADD, 4'd6, 4'd4, 4'd5));
		emit(asm_i(cpu_pkg::OP_STW, 4'd2, 4'd0, 16'd32));
		emit(asm_i(cpu_pkg::OP_STW, 4'd3, 4'd0, 16'd36));
		emit(asm_i(cpu_pkg::OP_STW, 4'd4, 4'd0, 16'd40));
		emit(asm_i(cpu_pkg::OP_STW, 4'd5, 4'd0, 16'd44));
		emit(asm_i(cpu_pkg::OP_STW, 4'd6, 4'd0, 16'd48));
		emit(asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'd0));
		run_program();
		r1 = 32'd3;	// Sequential model of the program
		r2 = r1 + 32'd4;
		r3 = r1 + 32'd10;
		r4 = r2 + r3;
		r5 = r4 - r1;
		r4 = r4 + r4;
		r6 = r4 + r5;
		check_mem(8, r2);
		check_mem(9, r3);
		check_mem(10, r4);
		check_mem(11, r5);
		check_mem(12, r6);
	endtask

	task automatic test_loads();
		logic [31:0] sum;
		new_program();
		dmem_init[16] = 32'h0001_2345;
		dmem_init[17] = 32'h00ab_0000;
		dmem_init[18] = 32'h7000_0001;
		sum = dmem_init[16] + dmem_init[17] + dmem_init[18];
		emit(asm_i(cpu_pkg::OP_LDW, 4'd1, 4'd0, 16'd64));
		emit(asm_i(cpu_pkg::OP_LDW, 4'd2, 4'd0, 16'd68));
		emit(asm_r(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));	// Uses r2 right away
		emit(asm_i(cpu_pkg::OP_LDW, 4'd4, 4'd0, 16'd72));
		emit(asm_r(cpu_pkg::OP_ADD, 4'd5, 4'd3, 4'd4));
		emit(asm_i(cpu_pkg::OP_STW, 4'd5, 4'd0, 16'd80));
		emit(asm_i(cpu_pkg::OP_LDW, 4'd6, 4'd0, 16'd80));
		emit(asm_i(cpu_pkg::OP_STW, 4'd6, 4'd0, 16'd84));	// Load data as store data
		emit(asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'd0));
		run_program();
		check_mem(20, sum);
		check_mem(21, sum);
	endtask

	task automatic test_branches();
		new_program();
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'd7));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd2, 4'd0, 16'd7));
		emit(asm_i(cpu_pkg::OP_BEQ, 4'd2, 4'd1, 16'd2));	// Taken, skips two
		emit(asm_i(cpu_pkg::OP_STW, 4'd1, 4'd0, 16'd96));
		emit(asm_i(cpu_pkg::OP_STW, 4'd1, 4'd0, 16'd100));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd3, 4'd0, 16'd9));
		emit(asm_i(cpu_pkg::OP_BEQ, 4'd3, 4'd1, 16'd1));	// Not taken
		emit(asm_i(cpu_pkg::OP_STW, 4'd3, 4'd0, 16'd104));
		emit(asm_i(cpu_pkg::OP_STW, 4'd2, 4'd0, 16'd108));
		emit(asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'd0));
		run_program();
		check_mem(24, fill_word(24));
		check_mem(25, fill_word(25));
		check_mem(26, 32'd9);
		check_mem(27, 32'd7);
	endtask

	task automatic test_reg0_undef();
		new_program();
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd0, 4'd0, 16'h0055));
		emit(asm_i(cpu_pkg::OP_STW, 4'd0, 4'd0, 16'd112));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'h0021));
		emit({8'h0c, 4'd1, 4'd1, 16'd5});	// Unused opcode
		emit({8'h17, 4'd1, 4'd1, 16'h0100});	// ADDI nibble with upper bits set
		emit(asm_i(cpu_pkg::OP_STW, 4'd1, 4'd0, 16'd116));
		emit(asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'd0));
		run_program();
		check_mem(28, 32'd0);
		check_mem(29, 32'h21);
	endtask

	task automatic test_halt();
		new_program();
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd1, 4'd0, 16'h0066));
		emit(asm_i(cpu_pkg::OP_STW, 4'd1, 4'd0, 16'd120));
		emit(asm_i(cpu_pkg::OP_HALT, 4'd0, 4'd0, 16'd0));
		emit(asm_i(cpu_pkg::OP_STW, 4'd1, 4'd0, 16'd124));
		emit(asm_i(cpu_pkg::OP_ADDI, 4'd1, 4'd1, 16'd1));
		run_program();
		repeat (20) begin
			@(negedge clk);
			check_eq("o_i_req", {31'b0, i_req}, 32'd0);
			check_eq("o_d_req", {31'b0, d_req}, 32'd0);
		end
		check_mem(30, 32'h66);
		check_mem(31, fill_word(31));
	endtask

	initial begin
		test_alu();
		test_forwarding();
		test_loads();
		test_branches();
		test_reg0_undef();
		test_halt();
		if (dut_i.props_i.fail_count != 0) begin
			$display("bus protocol assertion failed %0d times", dut_i.props_i.fail_count);
			$display("Simulation finished: FAIL");
			$fatal(1);
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_fetch.sv
design/cpu_decode.sv
design/cpu_regfile.sv
design/cpu_exec.sv
design/cpu_memory.sv
design/cpu_core.sv
bench/cpu_tb_clock.sv
bench/cpu_properties.sv
bench/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/cpu_fetch.sv
      - design/cpu_decode.sv
      - design/cpu_regfile.sv
      - design/cpu_exec.sv
      - design/cpu_memory.sv
      - design/cpu_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/cpu_tb_clock.sv
      - bench/cpu_properties.sv
      - bench/cpu_tb.sv
